//--- source/subseq_pkg.sv
`default_nettype none

package subseq_pkg;

    localparam int DATA_WIDTH = 16;
    localparam int MAX_KEEP   = 12;                     // Stack capacity and largest keep count
    localparam int LEN_WIDTH  = 8;

    localparam int INDEX_WIDTH = $clog2(MAX_KEEP + 1);  // Must hold MAX_KEEP itself

    // Words left, keep count and depths
    typedef logic [LEN_WIDTH-1:0] count_t;

    typedef logic [INDEX_WIDTH-1:0] index_t;

    typedef struct packed {
        logic [LEN_WIDTH-1:0] seq_len;                  // Number of data words in the job
        logic [LEN_WIDTH-1:0] keep;                     // Length of the result
    } header_t;

    // One input word, read as a header or as data depending on decoder state
    typedef union packed {
        header_t               header;
        logic [DATA_WIDTH-1:0] data;
    } subseq_word_u;

endpackage

`default_nettype wire

//--- source/word_decoder.sv
`default_nettype none

module word_decoder (
    input  logic                              clock,
    input  logic                              reset,
    input  subseq_pkg::subseq_word_u          word_i,
    input  logic                              word_valid_i,
    input  logic                              streaming_i,
    output logic [subseq_pkg::DATA_WIDTH-1:0] data_o,
    output logic                              data_valid_o,
    output subseq_pkg::count_t                nums_left_o,
    output subseq_pkg::count_t                keep_o,
    output logic                              clear_o,
    output logic                              seq_done_o
);

    import subseq_pkg::*;

    logic   in_data;                                    // High while data words are expected
    count_t nums_left_q;
    count_t keep_q;
    logic   seq_done_q;

    logic   header_accept;
    logic   data_accept;
    logic   last_data;

    assign header_accept = word_valid_i && !in_data;
    assign data_accept   = word_valid_i && in_data;
    assign last_data     = data_accept && (nums_left_q == count_t'(1));

    assign data_o       = word_i.data;
    assign data_valid_o = data_accept;
    assign nums_left_o  = nums_left_q;                  // Includes the word on data_o
    assign keep_o       = keep_q;
    assign clear_o      = header_accept;
    assign seq_done_o   = seq_done_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            in_data     <= 1'b0;
            nums_left_q <= '0;
            keep_q      <= '0;
            seq_done_q  <= 1'b0;
        end else begin
            seq_done_q <= last_data;                    // One cycle after the final data edge
            if (header_accept) begin
                in_data     <= 1'b1;
                nums_left_q <= word_i.header.seq_len;
                keep_q      <= word_i.header.keep;
            end else if (data_accept) begin
                nums_left_q <= nums_left_q - count_t'(1);
                if (last_data) begin
                    in_data <= 1'b0;
                end
            end
        end
    end

    header_len_nonzero: assert property (
        @(posedge clock) disable iff (reset)
        header_accept |-> (word_i.header.seq_len != '0)
    ) else $error("Header with zero sequence length");

    header_keep_range: assert property (
        @(posedge clock) disable iff (reset)
        header_accept |-> (word_i.header.keep != '0) &&
                          (int'(word_i.header.keep) <= MAX_KEEP)
    ) else $error("Header keep count outside 1 to %0d", MAX_KEEP);

    // The sender has to wait for the last result word before the next job
    no_word_during_readout: assert property (
        @(posedge clock) disable iff (reset)
        (streaming_i || seq_done_q) |-> !word_valid_i
    ) else $error("Input word arrived while the result was pending");

endmodule

`default_nettype wire

//--- source/greedy_stack.sv
`default_nettype none

module greedy_stack (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              clear_i,
    input  logic [subseq_pkg::DATA_WIDTH-1:0] data_i,
    input  logic                              data_valid_i,
    input  subseq_pkg::count_t                nums_left_i,
    input  subseq_pkg::count_t                keep_i,
    input  subseq_pkg::index_t                peek_index_i,
    output logic [subseq_pkg::DATA_WIDTH-1:0] peek_o,
    output subseq_pkg::index_t                depth_o
);

    import subseq_pkg::*;

    logic [DATA_WIDTH-1:0] entries [MAX_KEEP];
    index_t                sp;                          // Number of filled entries

    logic                  pop_run;
    index_t                insert_at;
    logic                  has_room;
    logic                  write_en;

    assign depth_o = sp;
    assign peek_o  = entries[peek_index_i];

    // An entry may go when it is below the new word, every entry above it
    // also goes, and the words still to come can refill the stack to keep_i.
    // Popping entry i leaves i entries, the new word makes i + 1 and
    // nums_left_i - 1 words follow, so i + nums_left_i must reach keep_i.
    always_comb begin
        pop_run   = 1'b1;
        insert_at = sp;
        for (int i = MAX_KEEP - 1; i >= 0; i--) begin
            if (i < int'(sp)) begin
                pop_run = pop_run && (entries[i] < data_i) &&
                          ((i + int'(nums_left_i)) >= int'(keep_i));
                if (pop_run) begin
                    insert_at = index_t'(i);            // Deepest entry of the run so far
                end
            end
        end
    end

    assign has_room = count_t'(sp) < keep_i;
    assign write_en = data_valid_i && ((insert_at != sp) || has_room);

    always_ff @(posedge clock) begin
        if (reset || clear_i) begin
            sp <= '0;
            for (int i = 0; i < MAX_KEEP; i++) begin
                entries[i] <= '1;
            end
        end else if (write_en) begin
            entries[insert_at] <= data_i;               // Overwrites the popped run or pushes
            sp                 <= insert_at + index_t'(1);
        end
    end

    depth_within_keep: assert property (
        @(posedge clock) disable iff (reset)
        count_t'(sp) <= keep_i
    ) else $error("Stack depth %0d above keep count %0d", sp, keep_i);

    peek_in_range: assert property (
        @(posedge clock) disable iff (reset)
        peek_index_i < index_t'(MAX_KEEP)
    ) else $error("Peek index %0d outside the stack", peek_index_i);

endmodule

`default_nettype wire

//--- source/result_streamer.sv
`default_nettype none

module result_streamer (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              seq_done_i,
    input  subseq_pkg::index_t                depth_i,
    input  logic [subseq_pkg::DATA_WIDTH-1:0] peek_i,
    output subseq_pkg::index_t                peek_index_o,
    output logic [subseq_pkg::DATA_WIDTH-1:0] result_o,
    output logic                              result_valid_o,
    output logic                              result_last_o,
    output logic                              streaming_o
);

    import subseq_pkg::*;

    logic   streaming_q;
    index_t count_q;                                    // Entry shown this cycle
    index_t depth_q;
    logic   at_last;

    assign at_last = (count_q == depth_q - index_t'(1));

    assign peek_index_o   = count_q;
    assign result_o       = peek_i;
    assign result_valid_o = streaming_q;
    assign result_last_o  = streaming_q && at_last;
    assign streaming_o    = streaming_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            streaming_q <= 1'b0;
            count_q     <= '0;
            depth_q     <= '0;
        end else if (seq_done_i) begin
            streaming_q <= (depth_i != '0);
            count_q     <= '0;                          // Bottom of the stack comes out first
            depth_q     <= depth_i;
        end else if (streaming_q) begin
            if (at_last) begin
                streaming_q <= 1'b0;
                count_q     <= '0;
            end else begin
                count_q <= count_q + index_t'(1);
            end
        end
    end

    done_while_idle: assert property (
        @(posedge clock) disable iff (reset)
        seq_done_i |-> !streaming_q
    ) else $error("End of sequence during result readout");

endmodule

`default_nettype wire

//--- source/subseq_top.sv
`default_nettype none

module subseq_top (
    input  logic                              clock,
    input  logic                              reset,
    input  subseq_pkg::subseq_word_u          word_i,
    input  logic                              word_valid_i,
    output logic [subseq_pkg::DATA_WIDTH-1:0] result_o,
    output logic                              result_valid_o,
    output logic                              result_last_o
);

    import subseq_pkg::*;

    logic [DATA_WIDTH-1:0] data;
    logic                  data_valid;
    count_t                nums_left;
    count_t                keep;
    logic                  clear;
    logic                  seq_done;
    logic                  streaming;
    index_t                depth;
    index_t                peek_index;
    logic [DATA_WIDTH-1:0] peek;

    word_decoder i_decoder (
        .clock        (clock),
        .reset        (reset),
        .word_i       (word_i),
        .word_valid_i (word_valid_i),
        .streaming_i  (streaming),
        .data_o       (data),
        .data_valid_o (data_valid),
        .nums_left_o  (nums_left),
        .keep_o       (keep),
        .clear_o      (clear),
        .seq_done_o   (seq_done)
    );

    greedy_stack i_stack (
        .clock        (clock),
        .reset        (reset),
        .clear_i      (clear),
        .data_i       (data),
        .data_valid_i (data_valid),
        .nums_left_i  (nums_left),
        .keep_i       (keep),
        .peek_index_i (peek_index),
        .peek_o       (peek),
        .depth_o      (depth)
    );

    result_streamer i_streamer (
        .clock          (clock),
        .reset          (reset),
        .seq_done_i     (seq_done),
        .depth_i        (depth),
        .peek_i         (peek),
        .peek_index_o   (peek_index),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .result_last_o  (result_last_o),
        .streaming_o    (streaming)
    );

endmodule

`default_nettype wire

//--- verification/clock_gen.sv
`default_nettype none

module clock_gen (
    output logic clock_o
);

    localparam int HALF_PERIOD = 4;                     // Full period of 8 time units

    initial begin
        clock_o = 1'b0;
        forever begin
            #HALF_PERIOD;
            clock_o = ~clock_o;
        end
    end

endmodule

`default_nettype wire

//--- verification/subseq_tb.sv
`default_nettype none

module subseq_tb;

    import subseq_pkg::*;

    localparam int SEED         = 36892;
    localparam int RESET_CYCLES = 4;
    localparam int RANDOM_JOBS  = 40;
    localparam int ASCENDING    = 0;
    localparam int DESCENDING   = 1;
    localparam int RANDOM       = 2;

    logic                  clock;
    logic                  reset;
    subseq_word_u          word_i;
    logic                  word_valid_i;
    logic [DATA_WIDTH-1:0] result_o;
    logic                  result_valid_o;
    logic                  result_last_o;

    logic [DATA_WIDTH-1:0] word_q [$];                  // Data words of all jobs, back to back
    int                    len_q [$];
    int                    keep_q [$];
    int                    start_q [$];
    logic [DATA_WIDTH-1:0] expected_q [$];
    logic                  last_q [$];

    int                    result_count;
    int                    released_count;              // Results the DUT may have produced so far
    int                    budget_cycles;
    logic                  last_data_sent;

    clock_gen i_clock_gen (
        .clock_o (clock)
    );

    subseq_top i_dut (
        .clock          (clock),
        .reset          (reset),
        .word_i         (word_i),
        .word_valid_i   (word_valid_i),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .result_last_o  (result_last_o)
    );

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "Stopping at the first error");
    endtask

    // Windowed selection picks the earliest maximum among the words that
    // still leave enough words behind it
    function automatic void add_expected(input int start, input int len, input int keep);
        int take;
        int from;
        int pick;
        take = (keep < len) ? keep : len;
        from = start;
        for (int j = 0; j < take; j++) begin
            pick = from;
            for (int i = from; i <= start + len - take + j; i++) begin
                if (word_q[i] > word_q[pick]) begin
                    pick = i;
                end
            end
            expected_q.push_back(word_q[pick]);
            last_q.push_back(j == take - 1);
            from = pick + 1;
        end
    endfunction

    function automatic logic [DATA_WIDTH-1:0] expected_word_at(input int n);
        logic [DATA_WIDTH-1:0] word;
        word = '0;
        if (n < expected_q.size()) begin
            word = expected_q[n];
        end
        return word;
    endfunction

    function automatic logic expected_last_at(input int n);
        logic last;
        last = 1'b0;
        if (n < last_q.size()) begin
            last = last_q[n];
        end
        return last;
    endfunction

    function automatic void add_job(input int len, input int keep, input int pattern);
        int start;
        start = word_q.size();
        for (int i = 0; i < len; i++) begin
            case (pattern)
                ASCENDING:  word_q.push_back(DATA_WIDTH'(10 + i));
                DESCENDING: word_q.push_back(DATA_WIDTH'(500 - 3 * i));
                default:    word_q.push_back(DATA_WIDTH'($urandom % 6));  // Small range gives ties
            endcase
        end
        len_q.push_back(len);
        keep_q.push_back(keep);
        start_q.push_back(start);
        add_expected(start, len, keep);
    endfunction

    task automatic run_job(input int j);
        word_i.header.seq_len = count_t'(len_q[j]);
        word_i.header.keep    = count_t'(keep_q[j]);
        word_valid_i          = 1'b1;
        @(posedge clock);
        #1;
        for (int i = 0; i < len_q[j]; i++) begin
            word_i.data = word_q[start_q[j] + i];
            if (i == len_q[j] - 1) begin
                last_data_sent = 1'b1;
                released_count = released_count +
                                 ((keep_q[j] < len_q[j]) ? keep_q[j] : len_q[j]);
            end
            @(posedge clock);
            #1;
        end
        word_valid_i   = 1'b0;
        word_i         = '0;
        last_data_sent = 1'b0;
        do begin
            @(posedge clock);
        end while (!result_last_o);
        #1;                                             // Next header goes out right after the last result
    endtask

    always_ff @(posedge clock) begin
        if (reset) begin
            result_count <= 0;
        end else if (result_valid_o) begin
            result_count <= result_count + 1;
        end
    end

    result_value: assert property (
        @(posedge clock) disable iff (reset)
        result_valid_o |-> (result_o == expected_word_at(result_count))
    ) else stop_with_failure($sformatf("[FAIL] result_o expected %h actual %h",
                                       expected_word_at($sampled(result_count)),
                                       $sampled(result_o)));

    result_last_flag: assert property (
        @(posedge clock) disable iff (reset)
        result_valid_o |-> (result_last_o == expected_last_at(result_count))
    ) else stop_with_failure($sformatf("[FAIL] result_last_o expected %h actual %h",
                                       expected_last_at($sampled(result_count)),
                                       $sampled(result_last_o)));

    // Also covers the quiet outputs before the first job ends
    result_not_early: assert property (
        @(posedge clock) disable iff (reset)
        result_valid_o |-> (result_count < released_count)
    ) else stop_with_failure("Result word appeared with no result pending");

    last_needs_valid: assert property (
        @(posedge clock) disable iff (reset)
        result_last_o |-> result_valid_o
    ) else stop_with_failure("result_last_o was high without result_valid_o");

    first_result_latency: assert property (
        @(posedge clock) disable iff (reset)
        (last_data_sent && word_valid_i) |-> ##1 !result_valid_o ##1 result_valid_o
    ) else stop_with_failure("First result word was not valid two cycles after the last data");

    results_back_to_back: assert property (
        @(posedge clock) disable iff (reset)
        (result_valid_o && !result_last_o) |=> result_valid_o
    ) else stop_with_failure("Gap between result words of one job");

    initial begin
        wait (budget_cycles > 0);
        repeat (budget_cycles) @(posedge clock);
        stop_with_failure($sformatf("Run did not finish within %0d cycles", budget_cycles));
    end

    initial begin
        int budget;
        reset          = 1'b1;
        word_i         = '0;
        word_valid_i   = 1'b0;
        last_data_sent = 1'b0;
        released_count = 0;
        budget_cycles  = 0;
        void'($urandom(SEED));

        add_job(10, 4, ASCENDING);
        add_job(10, 4, DESCENDING);
        add_job(20, 12, RANDOM);
        add_job(3, 8, ASCENDING);                       // Shorter than keep right after a full stack
        add_job(5, 12, DESCENDING);
        for (int n = 0; n < RANDOM_JOBS; n++) begin
            add_job(1 + int'($urandom % 30), 1 + int'($urandom % MAX_KEEP), RANDOM);
        end
        add_job(1, 1, RANDOM);

        budget = RESET_CYCLES;
        for (int j = 0; j < len_q.size(); j++) begin
            budget = budget + len_q[j] + keep_q[j] + 4;
        end
        budget_cycles = 2 * budget;

        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;
        @(posedge clock);
        #1;

        for (int j = 0; j < len_q.size(); j++) begin
            run_job(j);
        end
        repeat (2) @(posedge clock);
        #1;

        if (result_count != expected_q.size()) begin
            stop_with_failure($sformatf("Saw %0d result words but expected %0d",
                                        result_count, expected_q.size()));
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- build.f
source/subseq_pkg.sv
source/word_decoder.sv
source/greedy_stack.sv
source/result_streamer.sv
source/subseq_top.sv
verification/clock_gen.sv
verification/subseq_tb.sv

//--- Bender.yml
package:
  name: subseq

sources:
  - files:
      - source/subseq_pkg.sv
      - source/word_decoder.sv
      - source/greedy_stack.sv
      - source/result_streamer.sv
      - source/subseq_top.sv
  - target: test
    files:
      - verification/clock_gen.sv
      - verification/subseq_tb.sv
